// ==== sim/dcache_golden.txt ====
# kind (0 idle, 1 read, 2 write), address, size code, write data, expected read data,
# number of miss requests, number of evictions
0 00000000 0 0000000000000000 0000000000000000 0 0
# Cold read, then the same read as a hit
1 00000100 3 0000000000000000 0706050403020100 1 0
1 00000100 3 0000000000000000 0706050403020100 0 0
# Byte write hit merged into the line
2 00000104 0 00000000000000aa 0000000000000000 0 0
1 00000100 3 0000000000000000 070605aa03020100 0 0
1 00000106 1 0000000000000000 0000000000000706 0 0
# Halfword write miss allocates the line
2 00000208 1 000000000000beef 0000000000000000 1 0
1 00000208 2 0000000000000000 000000000b0abeef 0 0
# Doubleword write miss, then a read of the same index evicts it
2 00000110 3 1122334455667788 0000000000000000 1 0
1 00000110 3 0000000000000000 1122334455667788 0 0
1 00000310 3 0000000000000000 1716151413121110 1 1
1 00000110 3 0000000000000000 1122334455667788 1 0
# Dirty line of byte write evicted and read back from memory
1 00000508 1 0000000000000000 0000000000000908 1 1
1 00000100 3 0000000000000000 070605aa03020100 1 0
# Uncached I/O read and write
1 80000024 2 0000000000000000 0000000000000024 0 0
2 80000033 2 00000000cafef00d 0000000000000000 0 0
# Accesses crossing a line boundary at offset 12
1 0000011c 3 0000000000000000 232221201f1e1d1c 1 0
2 0000022c 3 0102030405060708 0000000000000000 2 0
1 0000022c 3 0000000000000000 0102030405060708 0 0
1 00000228 3 0000000000000000 050607082b2a2928 0 0
0 00000000 0 0000000000000000 0000000000000000 0 0

// ==== files.f ====
+incdir+source
source/dcache_pkg.sv
source/dc_arbiter.sv
source/dc_tag_store.sv
source/dc_data_store.sv
source/dc_wr_data_gen.sv
source/dc_rd_data_gen.sv
source/dc_hit_checker.sv
source/dcache.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module dcache_tb -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1

// ==== sim/dcache_tb.sv ====
/* Testbench of the data cache. Runs the operations of the golden file against
   the DUT, with a memory unit model for misses and a responder for I/O */
`default_nettype none
`include "dcache_params.svh"

module dcache_tb
  import dcache_pkg::*;
();

  localparam int DONE_LIMIT = 200;

  logic                  clk;
  logic                  arst_n;
  logic                  v_mem_read;
  logic                  mem_conflict;
  logic                  wr_fifo_empty;
  logic                  wr_fifo_to_be_full;
  dc_req_t               rd_req;
  dc_req_t               wr_req;
  logic [`DC_LINE_W-1:0] dc_data_fill;
  logic                  dc_miss_ack;
  logic [31:0]           io_rd_data;
  logic                  io_ack;
  logic [63:0]           mem_rd_data;
  logic                  mem_rd_ready;
  logic                  mem_wr_done;
  logic                  mem_rd_busy;
  logic                  mem_wr_busy;
  dc_miss_t              dc_miss_out;
  io_req_t               io_out;

  logic        op_start;
  logic        op_end;
  logic        op_idle;
  logic [1:0]  op_kind;
  logic [31:0] op_addr;
  logic [1:0]  op_size;
  logic [63:0] op_wdata;
  logic [63:0] op_exp;
  int          op_misses;
  int          op_evicts;
  int          err_count;
  int          test_count;
  int          seed;
  logic        timed_out;

  // Backing memory preloaded with the low address byte
  logic [7:0] mem [0:32767];

  initial clk = 1'b0;
  always #2 clk = ~clk;

  dcache UUT (
    .clk (clk), .arst_n (arst_n), .v_mem_read (v_mem_read), .mem_conflict (mem_conflict),
    .wr_fifo_empty (wr_fifo_empty), .wr_fifo_to_be_full (wr_fifo_to_be_full),
    .rd_req (rd_req), .wr_req (wr_req), .dc_data_fill (dc_data_fill),
    .dc_miss_ack (dc_miss_ack), .io_rd_data (io_rd_data), .io_ack (io_ack),
    .mem_rd_data (mem_rd_data), .mem_rd_ready (mem_rd_ready), .mem_wr_done (mem_wr_done),
    .mem_rd_busy (mem_rd_busy), .mem_wr_busy (mem_wr_busy), .dc_miss_out (dc_miss_out),
    .io_out (io_out)
  );

  dcache_checker u_checker (
    .clk (clk), .arst_n (arst_n), .op_start (op_start), .op_end (op_end),
    .op_idle (op_idle), .op_kind (op_kind), .op_addr (op_addr), .op_size (op_size),
    .op_wdata (op_wdata), .op_exp (op_exp), .op_misses (op_misses),
    .op_evicts (op_evicts), .mem_rd_data (mem_rd_data), .mem_rd_ready (mem_rd_ready),
    .mem_wr_done (mem_wr_done), .mem_rd_busy (mem_rd_busy), .mem_wr_busy (mem_wr_busy),
    .dc_miss_out (dc_miss_out), .io_out (io_out), .err_count (err_count),
    .test_count (test_count)
  );

  task automatic run_op(input logic [1:0] kind, input logic [31:0] addr,
                        input logic [1:0] size, input logic [63:0] wdata,
                        input logic [63:0] exp, input int misses, input int evicts);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    op_kind   <= kind;
    op_addr   <= addr;
    op_size   <= size;
    op_wdata  <= wdata;
    op_exp    <= exp;
    op_misses <= misses;
    op_evicts <= evicts;
    op_start  <= 1'b1;
    if (kind == 2'd1) begin
      rd_req.addr.raw <= addr;
      rd_req.size     <= size;
      rd_req.wdata    <= '0;
      v_mem_read      <= 1'b1;
    end else if (kind == 2'd2) begin
      wr_req.addr.raw <= addr;
      wr_req.size     <= size;
      wr_req.wdata    <= wdata;
      wr_fifo_empty   <= 1'b0;
    end else begin
      op_idle <= 1'b1;
    end
    @(posedge clk);
    op_start <= 1'b0;
    if (kind == 2'd0) begin
      repeat (8) @(posedge clk);
    end else begin
      while (!done && cycles < DONE_LIMIT) begin
        @(negedge clk);
        done = (kind == 2'd1) ? mem_rd_ready : mem_wr_done;
        cycles++;
      end
      @(posedge clk);
    end
    if (!done && kind != 2'd0) begin
      $display("Timeout: request at address %h never completed", addr);
      timed_out = 1'b1;
    end else begin
      v_mem_read    <= 1'b0;
      wr_fifo_empty <= 1'b1;
      op_idle       <= 1'b0;
      op_end        <= 1'b1;
      @(posedge clk);
      op_end <= 1'b0;
    end
  endtask

  // Memory unit model writes back the victim before returning the line
  initial begin
    int                    wait_cycles;
    logic [14:0]           base;
    logic [`DC_LINE_W-1:0] fill;
    forever begin
      @(negedge clk);
      if (arst_n && dc_miss_out.miss) begin
        wait_cycles = int'({$random(seed)} % 4) + 1;
        repeat (wait_cycles - 1) @(negedge clk);
        if (dc_miss_out.evict) begin
          base = dc_miss_out.evict_addr[14:0];
          for (int b = 0; b < `DC_LINE_BYTES; b++) begin
            mem[base + 15'(b)] = dc_miss_out.evict_data[b*8 +: 8];
          end
        end
        base = dc_miss_out.miss_addr[14:0];
        for (int b = 0; b < `DC_LINE_BYTES; b++) begin
          fill[b*8 +: 8] = mem[base + 15'(b)];
        end
        @(posedge clk);
        dc_data_fill <= fill;
        dc_miss_ack  <= 1'b1;
        @(posedge clk);
        dc_miss_ack <= 1'b0;
      end
    end
  end

  // I/O responder returns the address with bit 31 flipped as read data
  initial begin
    int wait_cycles;
    forever begin
      @(negedge clk);
      if (arst_n && io_out.access) begin
        wait_cycles = int'({$random(seed)} % 4) + 1;
        repeat (wait_cycles - 1) @(negedge clk);
        if (io_out.rw) begin
          $display("I/O write addr %h data %h", io_out.addr, io_out.wr_data);
        end
        @(posedge clk);
        io_rd_data <= io_out.addr ^ 32'h8000_0000;
        io_ack     <= 1'b1;
        @(posedge clk);
        io_ack <= 1'b0;
      end
    end
  end

  initial begin
    int          fd;
    int          r;
    string       line;
    logic [31:0] k;
    logic [31:0] a;
    logic [31:0] s;
    logic [63:0] w;
    logic [63:0] e;
    int          m;
    int          v;
    seed = 15;
    timed_out = 1'b0;
    arst_n = 1'b0;
    v_mem_read = 1'b0;
    mem_conflict = 1'b0;
    wr_fifo_empty = 1'b1;
    wr_fifo_to_be_full = 1'b0;
    rd_req = '0;
    wr_req = '0;
    dc_data_fill = '0;
    dc_miss_ack = 1'b0;
    io_rd_data = '0;
    io_ack = 1'b0;
    op_start = 1'b0;
    op_end = 1'b0;
    op_idle = 1'b0;
    op_kind = '0;
    op_addr = '0;
    op_size = '0;
    op_wdata = '0;
    op_exp = '0;
    op_misses = 0;
    op_evicts = 0;
    for (int i = 0; i < 32768; i++) begin
      mem[i] = i[7:0];
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    fd = $fopen("sim/dcache_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file sim/dcache_golden.txt");
      $display("Simulation FAILED");
      $finish;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
          r = $sscanf(line, "%h %h %h %h %h %d %d", k, a, s, w, e, m, v);
          if (r == 7) begin
            run_op(k[1:0], a, s[1:0], w, e, m, v);
          end
        end
      end
      $fclose(fd);
      repeat (2) @(posedge clk);
      $display("Tests run: %0d, errors: %0d", test_count, err_count);
      if (!timed_out && err_count == 0 && test_count > 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sim/dcache_checker.sv ====
/* Watches the data cache ports during each golden operation, compares read data,
   miss, evict and I/O fields with the expected values and counts errors */
`default_nettype none
`include "dcache_params.svh"

module dcache_checker
  import dcache_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        op_start,
  input  logic        op_end,
  input  logic        op_idle,
  input  logic [1:0]  op_kind,
  input  logic [31:0] op_addr,
  input  logic [1:0]  op_size,
  input  logic [63:0] op_wdata,
  input  logic [63:0] op_exp,
  input  int          op_misses,
  input  int          op_evicts,
  input  logic [63:0] mem_rd_data,
  input  logic        mem_rd_ready,
  input  logic        mem_wr_done,
  input  logic        mem_rd_busy,
  input  logic        mem_wr_busy,
  input  dc_miss_t    dc_miss_out,
  input  io_req_t     io_out,
  output int          err_count,
  output int          test_count
);

  int          miss_seen;
  int          evict_seen;
  int          done_seen;
  int          op_errs;
  logic        miss_q;
  logic        exp_rd_busy;
  logic        exp_wr_busy;
  logic        op_cross;
  logic [31:0] line_a;
  logic [31:0] line_b;

  // Line of the access and the next line for a crossing access
  assign line_a   = {17'b0, op_addr[14:4], 4'h0};
  assign line_b   = {17'b0, op_addr[14:4] + 11'd1, 4'h0};
  assign op_cross = ({1'b0, op_addr[3:0]} + (5'd1 << op_size)) > 5'd16;

  task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    err_count++;
    op_errs++;
  endtask

  task automatic problem(input string msg);
    $display("Error at %0t: %s", $time, msg);
    err_count++;
    op_errs++;
  endtask

  initial begin
    err_count   = 0;
    test_count  = 0;
    miss_seen   = 0;
    evict_seen  = 0;
    done_seen   = 0;
    op_errs     = 0;
    miss_q      = 1'b0;
    exp_rd_busy = 1'b0;
    exp_wr_busy = 1'b0;
  end

  // Sampled mid-cycle away from the edge where inputs change
  always @(negedge clk) begin
    if (arst_n) begin
      if (op_start) begin
        miss_seen  = 0;
        evict_seen = 0;
        done_seen  = 0;
        op_errs    = 0;
      end
      if (op_idle && (mem_rd_ready || mem_wr_done || dc_miss_out.miss ||
                      dc_miss_out.evict || io_out.access)) begin
        problem("cache output active with no request");
      end
      // Busy while the request is open, the write one only once granted
      exp_rd_busy = (op_kind == 2'd1) && (done_seen == 0) && !mem_rd_ready;
      exp_wr_busy = (op_kind == 2'd2) && (done_seen == 0) && !op_start;
      if (mem_rd_busy !== exp_rd_busy) begin
        mismatch("mem_rd_busy", 64'(exp_rd_busy), 64'(mem_rd_busy));
      end
      if (mem_wr_busy !== exp_wr_busy) begin
        mismatch("mem_wr_busy", 64'(exp_wr_busy), 64'(mem_wr_busy));
      end
      // New miss request names the line of the access and a victim in the same set
      if (dc_miss_out.miss && !miss_q) begin
        miss_seen++;
        if (dc_miss_out.miss_addr !== line_a &&
            !(op_cross && dc_miss_out.miss_addr === line_b)) begin
          mismatch("miss_addr", {32'b0, line_a}, {32'b0, dc_miss_out.miss_addr});
        end
        if (dc_miss_out.evict) begin
          evict_seen++;
          if (dc_miss_out.evict_addr[8:4] != dc_miss_out.miss_addr[8:4] ||
              dc_miss_out.evict_addr[14:9] == dc_miss_out.miss_addr[14:9]) begin
            mismatch("evict_addr", {32'b0, dc_miss_out.miss_addr},
                     {32'b0, dc_miss_out.evict_addr});
          end
        end
      end
      miss_q = dc_miss_out.miss;
      if (mem_rd_ready) begin
        done_seen++;
        if (op_kind != 2'd1) begin
          problem("read completion without a read request");
        end else if (mem_rd_data !== op_exp) begin
          mismatch("mem_rd_data", op_exp, mem_rd_data);
        end
      end
      if (mem_wr_done) begin
        done_seen++;
        if (op_kind != 2'd2) begin
          problem("write completion without a write request");
        end
      end
      if (io_out.access) begin
        if (io_out.addr !== {op_addr[31:2], 2'b00}) begin
          mismatch("io_out.addr", {32'b0, op_addr[31:2], 2'b00}, {32'b0, io_out.addr});
        end
        if (io_out.rw !== (op_kind == 2'd2)) begin
          problem("I/O direction does not match the request");
        end else if (io_out.rw && io_out.wr_data !== op_wdata[31:0]) begin
          mismatch("io_out.wr_data", {32'b0, op_wdata[31:0]}, {32'b0, io_out.wr_data});
        end
      end
      if (op_end) begin
        if (op_kind != 2'd0) begin
          if (done_seen != 1) begin
            problem("request did not complete exactly once");
          end
          if (miss_seen != op_misses) begin
            mismatch("miss count", 64'(op_misses), 64'(miss_seen));
          end
          if (evict_seen != op_evicts) begin
            mismatch("evict count", 64'(op_evicts), 64'(evict_seen));
          end
        end
        test_count++;
        if (op_errs == 0) begin
          $display("test %0d kind %0d addr %h: ok", test_count, op_kind, op_addr);
        end else begin
          $display("test %0d kind %0d addr %h: %0d errors", test_count, op_kind, op_addr,
                   op_errs);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dcache.sv ====
/* Top of the direct-mapped write-back data cache. Serves the pipeline read
   port and the write FIFO, with line misses and uncached I/O sent outside */
`default_nettype none
`include "dcache_params.svh"

module dcache
  import dcache_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  v_mem_read,
  input  logic                  mem_conflict,
  input  logic                  wr_fifo_empty,
  input  logic                  wr_fifo_to_be_full,
  input  dc_req_t               rd_req,
  input  dc_req_t               wr_req,
  input  logic [`DC_LINE_W-1:0] dc_data_fill,
  input  logic                  dc_miss_ack,
  input  logic [31:0]           io_rd_data,
  input  logic                  io_ack,
  output logic [63:0]           mem_rd_data,
  output logic                  mem_rd_ready,
  output logic                  mem_wr_done,
  output logic                  mem_rd_busy,
  output logic                  mem_wr_busy,
  output dc_miss_t              dc_miss_out,
  output io_req_t               io_out
);

  logic                      ren;
  logic                      wen;
  dc_req_t                   cur_req;
  dc_addr_u                  cur_addr;
  dc_addr_u                  miss_line;
  dc_addr_u                  evict_line;
  logic                      second_half;
  dc_tag_entry_t             ts_entry;
  dc_tag_entry_t             ts_data_in;
  logic                      ts_wr;
  logic                      rd_hit;
  logic                      wr_hit;
  logic                      miss;
  logic                      evict;
  logic                      io_access;
  logic [`DC_LINE_W-1:0]     line_rd_data;
  logic [`DC_LINE_W-1:0]     line_wr_data;
  logic [`DC_LINE_BYTES-1:0] line_wr_mask;

  assign cur_req = ren ? rd_req : wr_req;

  // Second half of a crossing access works on the next line
  assign cur_addr = second_half ? cur_req.addr.raw + `DC_ADDR_W'(`DC_LINE_BYTES)
                                : cur_req.addr.raw;

  always_comb begin
    ts_data_in.tag   = cur_addr.f.tag;
    ts_data_in.valid = 1'b1;
    ts_data_in.dirty = wr_hit;
  end

  // Cached space spans only tag, index and offset
  always_comb begin
    miss_line          = cur_addr;
    miss_line.f.upper  = '0;
    miss_line.f.offset = '0;
    evict_line         = miss_line;
    evict_line.f.tag   = ts_entry.tag;
  end

  always_comb begin
    dc_miss_out.miss       = miss;
    dc_miss_out.miss_addr  = miss_line.raw;
    dc_miss_out.evict      = evict;
    dc_miss_out.evict_addr = evict_line.raw;
    dc_miss_out.evict_data = line_rd_data;
  end

  // One word per I/O access
  always_comb begin
    io_out.access  = io_access;
    io_out.rw      = wen;
    io_out.addr    = {cur_addr.raw[`DC_ADDR_W-1:2], 2'b00};
    io_out.wr_data = wr_req.wdata[31:0];
  end

  dc_arbiter u_dc_arbiter (
    .clk                (clk),
    .arst_n             (arst_n),
    .v_mem_read         (v_mem_read),
    .mem_conflict       (mem_conflict),
    .wr_fifo_empty      (wr_fifo_empty),
    .wr_fifo_to_be_full (wr_fifo_to_be_full),
    .mem_rd_ready       (mem_rd_ready),
    .mem_wr_done        (mem_wr_done),
    .ren                (ren),
    .wen                (wen)
  );

  dc_tag_store u_dc_tag_store (
    .clk      (clk),
    .arst_n   (arst_n),
    .index    (cur_addr.f.index),
    .wr       (ts_wr),
    .data_in  (ts_data_in),
    .data_out (ts_entry)
  );

  dc_data_store u_dc_data_store (
    .clk     (clk),
    .index   (cur_addr.f.index),
    .wr_mask (line_wr_mask),
    .wr_data (line_wr_data),
    .rd_data (line_rd_data)
  );

  dc_wr_data_gen u_dc_wr_data_gen (
    .wr_req      (wr_req),
    .second_half (second_half),
    .wr_hit      (wr_hit),
    .miss_ack    (dc_miss_ack),
    .data_fill   (dc_data_fill),
    .wr_data     (line_wr_data),
    .wr_mask     (line_wr_mask)
  );

  dc_rd_data_gen u_dc_rd_data_gen (
    .clk         (clk),
    .arst_n      (arst_n),
    .line_data   (line_rd_data),
    .rd_req      (rd_req),
    .second_half (second_half),
    .rd_hit      (rd_hit),
    .io_rd_data  (io_rd_data),
    .io_ack      (io_ack),
    .mem_rd_data (mem_rd_data)
  );

  dc_hit_checker u_dc_hit_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .ren          (ren),
    .wen          (wen),
    .v_mem_read   (v_mem_read),
    .cur_addr     (cur_addr),
    .size         (cur_req.size),
    .ts_entry     (ts_entry),
    .miss_ack     (dc_miss_ack),
    .io_ack       (io_ack),
    .rd_hit       (rd_hit),
    .wr_hit       (wr_hit),
    .second_half  (second_half),
    .ts_wr        (ts_wr),
    .io_access    (io_access),
    .mem_rd_ready (mem_rd_ready),
    .mem_wr_done  (mem_wr_done),
    .mem_rd_busy  (mem_rd_busy),
    .mem_wr_busy  (mem_wr_busy),
    .miss         (miss),
    .evict        (evict)
  );

endmodule

`default_nettype wire

// ==== source/dc_hit_checker.sv ====
/* Lookup control of the data cache: I/O, hit and miss decision, victim state,
   the second-half flag of line-crossing accesses and the completion pulses */
`default_nettype none
`include "dcache_params.svh"

module dc_hit_checker
  import dcache_pkg::*;
(
  input  logic          clk,
  input  logic          arst_n,
  input  logic          ren,
  input  logic          wen,
  input  logic          v_mem_read,
  input  dc_addr_u      cur_addr,
  input  logic [1:0]    size,
  input  dc_tag_entry_t ts_entry,
  input  logic          miss_ack,
  input  logic          io_ack,
  output logic          rd_hit,
  output logic          wr_hit,
  output logic          second_half,
  output logic          ts_wr,
  output logic          io_access,
  output logic          mem_rd_ready,
  output logic          mem_wr_done,
  output logic          mem_rd_busy,
  output logic          mem_wr_busy,
  output logic          miss,
  output logic          evict
);

  logic                  active;
  logic                  is_io;
  logic                  cached;
  logic                  hit;
  logic [`DC_OFFSET_W:0] end_off;
  logic                  crossing;
  logic                  last_half;
  logic                  io_done;

  assign active = ren | wen;
  assign is_io  = cur_addr.raw[`DC_IO_BASE_BIT];
  assign cached = active & ~is_io;

  assign hit = cached & ts_entry.valid & (ts_entry.tag == cur_addr.f.tag);

  // One past the last byte; beyond the line end means two accesses
  assign end_off  = {1'b0, cur_addr.f.offset} + ({{`DC_OFFSET_W{1'b0}}, 1'b1} << size);
  assign crossing = end_off > (`DC_OFFSET_W+1)'(`DC_LINE_BYTES);

  assign last_half = ~crossing | second_half;

  assign rd_hit = ren & hit;
  assign wr_hit = wen & hit;

  // Held until the fill arrives and the retry hits
  assign miss  = cached & ~hit;
  assign evict = miss & ts_entry.valid & ts_entry.dirty;

  assign io_access = active & is_io;
  assign io_done   = io_access & io_ack;

  // Write hit marks dirty, fill loads the line clean
  assign ts_wr = wr_hit | (miss & miss_ack);

  assign mem_rd_ready = ren & ((hit & last_half) | io_done);
  assign mem_wr_done  = wen & ((hit & last_half) | io_done);

  assign mem_rd_busy = v_mem_read & ~mem_rd_ready;
  assign mem_wr_busy = wen;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      second_half <= 1'b0;
    end else if (mem_rd_ready | mem_wr_done) begin
      second_half <= 1'b0;
    end else if (hit && crossing && !second_half) begin
      second_half <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/dc_rd_data_gen.sv ====
/* Forms mem_rd_data: bytes of the line shifted down to bit 0, the two halves
   of a line-crossing read joined, or the I/O word on its acknowledge */
`default_nettype none
`include "dcache_params.svh"

module dc_rd_data_gen
  import dcache_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`DC_LINE_W-1:0] line_data,
  input  dc_req_t               rd_req,
  input  logic                  second_half,
  input  logic                  rd_hit,
  input  logic [31:0]           io_rd_data,
  input  logic                  io_ack,
  output logic [63:0]           mem_rd_data
);

  logic [7:0]              byte_mask;
  logic [63:0]             size_mask;
  logic [`DC_LINE_W-1:0]   low_shift;
  logic [`DC_LINE_W-1:0]   high_shift;
  logic [`DC_OFFSET_W:0]   head_bytes;
  logic [63:0]             first_q;
  logic [63:0]             joined;

  assign byte_mask = dc_size_mask(rd_req.size);

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      size_mask[i*8 +: 8] = {8{byte_mask[i]}};
    end
  end

  // First line: requested bytes moved down to byte 0
  assign low_shift = line_data >> {rd_req.addr.f.offset, 3'b000};

  // Second line: its bytes go above those taken from the first line
  assign head_bytes = (`DC_OFFSET_W+1)'(`DC_LINE_BYTES) - {1'b0, rd_req.addr.f.offset};
  assign high_shift = line_data << {head_bytes, 3'b000};
  assign joined     = first_q | high_shift[63:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      first_q <= '0;
    end else if (rd_hit && !second_half) begin
      first_q <= low_shift[63:0];
    end
  end

  always_comb begin
    if (io_ack) begin
      mem_rd_data = {32'b0, io_rd_data};
    end else if (second_half) begin
      mem_rd_data = joined & size_mask;
    end else begin
      mem_rd_data = low_shift[63:0] & size_mask;
    end
  end

endmodule

`default_nettype wire

// ==== source/dc_wr_data_gen.sv ====
/* Builds the data store write: a whole line on a fill, or the store bytes
   moved to their offset on a write hit */
`default_nettype none
`include "dcache_params.svh"

module dc_wr_data_gen
  import dcache_pkg::*;
(
  input  dc_req_t                   wr_req,
  input  logic                      second_half,
  input  logic                      wr_hit,
  input  logic                      miss_ack,
  input  logic [`DC_LINE_W-1:0]     data_fill,
  output logic [`DC_LINE_W-1:0]     wr_data,
  output logic [`DC_LINE_BYTES-1:0] wr_mask
);

  logic [7:0]                  byte_mask;
  logic [2*`DC_LINE_BYTES-1:0] mask_span;
  logic [2*`DC_LINE_W-1:0]     data_span;

  assign byte_mask = dc_size_mask(wr_req.size);

  // Two lines wide so the part past the line end lands in the upper half
  assign mask_span = {{(2*`DC_LINE_BYTES-8){1'b0}}, byte_mask} << wr_req.addr.f.offset;
  assign data_span = {{(2*`DC_LINE_W-64){1'b0}}, wr_req.wdata}
                     << {wr_req.addr.f.offset, 3'b000};

  always_comb begin
    if (miss_ack) begin
      wr_data = data_fill;
      wr_mask = '1;
    end else if (wr_hit) begin
      if (second_half) begin
        wr_data = data_span[2*`DC_LINE_W-1:`DC_LINE_W];
        wr_mask = mask_span[2*`DC_LINE_BYTES-1:`DC_LINE_BYTES];
      end else begin
        wr_data = data_span[`DC_LINE_W-1:0];
        wr_mask = mask_span[`DC_LINE_BYTES-1:0];
      end
    end else begin
      wr_data = data_span[`DC_LINE_W-1:0];
      wr_mask = '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/dc_data_store.sv ====
/* Line data of the cache. One line is read combinationally and any set of
   its bytes is written at the clock edge */
`default_nettype none
`include "dcache_params.svh"

module dc_data_store (
  input  logic                     clk,
  input  logic [`DC_INDEX_W-1:0]   index,
  input  logic [`DC_LINE_BYTES-1:0] wr_mask,
  input  logic [`DC_LINE_W-1:0]    wr_data,
  output logic [`DC_LINE_W-1:0]    rd_data
);

  logic [`DC_LINE_W-1:0] lines [`DC_LINES];

  // Per-byte enables, a fill sets all of them
  always_ff @(posedge clk) begin
    for (int b = 0; b < `DC_LINE_BYTES; b++) begin
      if (wr_mask[b]) begin
        lines[index][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
    end
  end

  assign rd_data = lines[index];

endmodule

`default_nettype wire

// ==== source/dc_tag_store.sv ====
/* Tag, valid and dirty bits for the 32 cache lines. Read combinationally at
   the current index, written at the clock edge */
`default_nettype none
`include "dcache_params.svh"

module dc_tag_store
  import dcache_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [`DC_INDEX_W-1:0] index,
  input  logic                   wr,
  input  dc_tag_entry_t          data_in,
  output dc_tag_entry_t          data_out
);

  dc_tag_entry_t entries [`DC_LINES];

  // Every line starts invalid and clean
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `DC_LINES; i++) begin
        entries[i] <= '0;
      end
    end else if (wr) begin
      entries[index] <= data_in;
    end
  end

  assign data_out = entries[index];

endmodule

`default_nettype wire

// ==== source/dc_arbiter.sv ====
/* Read/write arbiter of the data cache. Holds one registered grant until the
   matching completion pulse, then picks again from the idle state */
`default_nettype none

module dc_arbiter (
  input  logic clk,
  input  logic arst_n,
  input  logic v_mem_read,
  input  logic mem_conflict,
  input  logic wr_fifo_empty,
  input  logic wr_fifo_to_be_full,
  input  logic mem_rd_ready,
  input  logic mem_wr_done,
  output logic ren,
  output logic wen
);

  logic rd_want;
  logic wr_want;
  logic wr_first;

  // A read overlapping a queued write has to wait for it
  assign rd_want = v_mem_read & ~mem_conflict;
  assign wr_want = ~wr_fifo_empty;

  // Write goes first when the FIFO is filling up or the read cannot go
  assign wr_first = wr_want & (wr_fifo_to_be_full | mem_conflict | ~rd_want);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ren <= 1'b0;
      wen <= 1'b0;
    end else if (ren | wen) begin
      // Drop the grant after its own completion
      if (ren && mem_rd_ready) begin
        ren <= 1'b0;
      end
      if (wen && mem_wr_done) begin
        wen <= 1'b0;
      end
    end else if (wr_first) begin
      wen <= 1'b1;
    end else if (rd_want) begin
      ren <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
/* Types shared by the data cache: address views, requests, tag entries and
   the miss and uncached I/O request bundles */
`default_nettype none
`include "dcache_params.svh"

package dcache_pkg;

  // Lookup view of a physical address
  typedef struct packed {
    logic [`DC_ADDR_W-`DC_TAG_W-`DC_INDEX_W-`DC_OFFSET_W-1:0] upper;
    logic [`DC_TAG_W-1:0]                                     tag;
    logic [`DC_INDEX_W-1:0]                                   index;
    logic [`DC_OFFSET_W-1:0]                                  offset;
  } dc_addr_fields_t;

  // Raw word for I/O and arithmetic, fields for the cache lookup
  typedef union packed {
    logic [`DC_ADDR_W-1:0] raw;
    dc_addr_fields_t       f;
  } dc_addr_u;

  typedef struct packed {
    dc_addr_u    addr;
    logic [1:0]  size;   // 0 to 3 gives 1, 2, 4, 8 bytes
    logic [63:0] wdata;
  } dc_req_t;

  typedef struct packed {
    logic [`DC_TAG_W-1:0] tag;
    logic                 valid;
    logic                 dirty;
  } dc_tag_entry_t;

  typedef struct packed {
    logic                  miss;
    logic [`DC_ADDR_W-1:0] miss_addr;
    logic                  evict;
    logic [`DC_ADDR_W-1:0] evict_addr;
    logic [`DC_LINE_W-1:0] evict_data;
  } dc_miss_t;

  typedef struct packed {
    logic                  access;
    logic                  rw;       // 1 is a write
    logic [`DC_ADDR_W-1:0] addr;
    logic [31:0]           wr_data;
  } io_req_t;

  // Low-aligned byte enables of an access
  function automatic logic [7:0] dc_size_mask(input logic [1:0] size);
    logic [7:0] mask;
    case (size)
      2'd0:    mask = 8'h01;
      2'd1:    mask = 8'h03;
      2'd2:    mask = 8'h0f;
      default: mask = 8'hff;
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire

// ==== source/dcache_params.svh ====
/* Geometry of the 512-byte direct-mapped data cache and the uncached I/O region.
   Included by the package and by every RTL file that sizes something from it */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Physical address width
`define DC_ADDR_W 32

// 32 lines of 16 bytes
`define DC_LINES 32
`define DC_LINE_BYTES 16
`define DC_LINE_W 128

// Address split, tag above index above byte offset
`define DC_TAG_W 6
`define DC_INDEX_W 5
`define DC_OFFSET_W 4

// Set in an address means uncached I/O
`define DC_IO_BASE_BIT 31

`endif
